/* src/video_geom_pkg.sv */
// Geometry, capture window and output raster constants for the line doubler.
// The panel is scaled down so that a full output frame stays short in simulation.
// Output counts are in output pixels, and each output pixel lasts two in_hs cycles.
// A field holds half of the stored lines. Interlaced fields fill the whole buffer.
// Counter widths below must be widened by hand if the geometry grows.
`default_nettype none

package video_geom_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame buffer.
	localparam int fb_width = 8; // Stored pixels per line.
	localparam int fb_height = 6; // Stored lines per frame.
	localparam int fb_field_lines = fb_height / 2; // Lines captured per field.
	localparam int fb_addr_w = 6; // Enough for fb_width * fb_height words.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Capture window on the input raster.
	localparam int in_h_offset = 2; // First captured pixel of a line.
	localparam int in_v_offset = 1; // First captured line of a field.
	localparam int in_pos_w = 8; // Input position counters saturate at this width.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output raster.
	localparam int out_h_fp = 4; // Horizontal sync starts at this pixel count.
	localparam int out_h_sw = 2;
	localparam int out_h_bp = 4;
	localparam int out_h_blank = out_h_fp + out_h_sw + out_h_bp;
	localparam int out_h_total = out_h_blank + 2 * fb_width; // Every stored pixel is shown twice.
	localparam int out_h_cnt_w = $clog2(out_h_total);

	// Vertical sync starts at this line count.
	localparam int out_v_bp = 1;
	localparam int out_v_sw = 1;
	localparam int out_v_blank = out_v_bp + out_v_sw + 1; // One quiet line follows the sync.
	localparam int out_v_offset = 1; // Border lines above the picture.
	localparam int out_v_total = out_v_blank + out_v_offset + fb_height + 1; // One line below.
	localparam int out_v_cnt_w = $clog2(out_v_total);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Interlace detection.
	localparam int detect_frames = 4; // Frames per observation window.
	localparam int detect_cnt_w = $clog2(detect_frames + 1);

endpackage

`default_nettype wire

/* src/pixel_pkg.sv */
// Pixel formats and write queue sizing.
// The SRAM stores RGB565 with red in the top bits of the word.
// The input word carries three 10-bit channels, red highest.
`default_nettype none

package pixel_pkg;

	// One stored pixel.
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// The SRAM buses move raw words, while the pixel logic looks at the colour fields.
	typedef union packed {
		logic [15:0] raw;
		rgb565_t rgb;
	} sram_word_u;

	// Top bit of each 10-bit channel in the input word.
	localparam int in_red_msb = 29;
	localparam int in_green_msb = 19;
	localparam int in_blue_msb = 9;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write queue.
	localparam int wq_depth = 4; // Entries, and also the credits handed out at reset.
	localparam int wq_cnt_w = 3; // Must hold the value wq_depth.
	localparam int wq_ptr_w = $clog2(wq_depth); // Index bits of a queue entry.

endpackage

`default_nettype wire

/* src/capture_addr.sv */
// Input side of the line doubler.
// Markers are one-cycle pulses already sampled on in_hs, and pix_valid qualifies pixels.
// A pixel that arrives together with line_end is taken at the position before the marker.
// Position counters saturate, so a missing marker cannot bring pixels back into the window.
// Pixels that find no credit left are dropped and never reach the SRAM.
`default_nettype none

module capture_addr (
	input  wire        in_hs,
	input  wire        rst,
	input  wire        pix_valid,
	input  wire [29:0] pix_data,
	input  wire        line_end,
	input  wire        frame_end,
	input  wire        field_odd,
	input  wire        interlaced,
	input  wire        credit_ret,
	output logic       wr_push,
	output logic [video_geom_pkg::fb_addr_w-1:0] wr_addr,
	output pixel_pkg::sram_word_u wr_data
);

	logic [video_geom_pkg::in_pos_w-1:0] x_pos; // Valid pixels since the last line_end.
	logic [video_geom_pkg::in_pos_w-1:0] y_pos; // Lines since the last frame_end.
	logic [pixel_pkg::wq_cnt_w-1:0] credits; // Free queue entries.
	logic in_window;
	logic take; // The current pixel is written.
	logic [video_geom_pkg::fb_addr_w-1:0] col;
	logic [video_geom_pkg::fb_addr_w-1:0] row;
	logic [video_geom_pkg::fb_addr_w-1:0] line_idx;
	logic [video_geom_pkg::fb_addr_w-1:0] pix_addr;
	pixel_pkg::sram_word_u pix_word;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Window test and address.
	always_comb begin
		in_window = (x_pos >= video_geom_pkg::in_h_offset) &&
			(x_pos < video_geom_pkg::in_h_offset + video_geom_pkg::fb_width) &&
			(y_pos >= video_geom_pkg::in_v_offset) &&
			(y_pos < video_geom_pkg::in_v_offset + video_geom_pkg::fb_field_lines);
		col = video_geom_pkg::fb_addr_w'(x_pos - video_geom_pkg::in_h_offset);
		row = video_geom_pkg::fb_addr_w'(y_pos - video_geom_pkg::in_v_offset);
		// Fields interleave in interlaced mode. The odd field takes the lower line of each pair.
		line_idx = interlaced ? {row[video_geom_pkg::fb_addr_w-2:0], field_odd} : row;
		pix_addr = video_geom_pkg::fb_addr_w'(line_idx * video_geom_pkg::fb_width) + col;
		take = pix_valid && in_window && (credits != '0); // No credit means the pixel is lost.
	end

	// Keep the top bits of every channel.
	always_comb begin
		pix_word.rgb.red = pix_data[pixel_pkg::in_red_msb -: 5];
		pix_word.rgb.green = pix_data[pixel_pkg::in_green_msb -: 6];
		pix_word.rgb.blue = pix_data[pixel_pkg::in_blue_msb -: 5];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Position counters.
	always_ff @(posedge in_hs) begin
		if (rst) begin
			x_pos <= '0;
			y_pos <= '0;
		end else begin
			if (line_end || frame_end) begin
				x_pos <= '0;
			end else if (pix_valid && x_pos != '1) begin
				x_pos <= x_pos + 1'b1;
			end
			if (frame_end) begin
				y_pos <= '0; // A new field starts at the top.
			end else if (line_end && y_pos != '1) begin
				y_pos <= y_pos + 1'b1;
			end
		end
	end

	// Credits leave with each push and come back as the queue drains.
	always_ff @(posedge in_hs) begin
		if (rst) begin
			credits <= pixel_pkg::wq_cnt_w'(pixel_pkg::wq_depth);
			wr_push <= 1'b0;
		end else begin
			case ({take, credit_ret})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // Both or neither leave the count as it is.
			endcase
			wr_push <= take;
		end
	end

	always_ff @(posedge in_hs) begin
		if (take) begin
			wr_addr <= pix_addr;
			wr_data <= pix_word;
		end
	end

endmodule

`default_nettype wire

/* src/interlace_detect.sv */
// Decides between interlaced and progressive input.
// field_odd is sampled only on frame_end, so it must be stable around that pulse.
// The mode changes only at the end of a window of detect_frames frames.
`default_nettype none

module interlace_detect (
	input  wire  in_hs,
	input  wire  rst,
	input  wire  frame_end,
	input  wire  field_odd,
	output logic interlaced
);

	logic [video_geom_pkg::detect_cnt_w-1:0] frames_left; // Frames left in this window.
	logic seen_even; // Some frame of this window ended on an even field.

	always_ff @(posedge in_hs) begin
		if (rst) begin
			frames_left <= video_geom_pkg::detect_cnt_w'(video_geom_pkg::detect_frames);
			seen_even <= 1'b0;
			interlaced <= 1'b0; // Start out progressive.
		end else if (frame_end) begin
			if (frames_left == 1) begin
				// The window closes here. This last frame still counts.
				interlaced <= seen_even || !field_odd;
				seen_even <= 1'b0;
				frames_left <= video_geom_pkg::detect_cnt_w'(video_geom_pkg::detect_frames);
			end else begin
				seen_even <= seen_even || !field_odd;
				frames_left <= frames_left - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/write_queue.sv */
// Small FIFO of pending SRAM writes.
// The capture side holds one credit per entry, so a push never meets a full queue.
// head_addr and head_data show the oldest entry whenever wq_empty is low.
// credit_ret follows each accepted pop by one cycle.
`default_nettype none

module write_queue (
	input  wire  in_hs,
	input  wire  rst,
	input  wire  wr_push,
	input  wire  [video_geom_pkg::fb_addr_w-1:0] wr_addr,
	input  wire  pixel_pkg::sram_word_u wr_data,
	input  wire  wq_pop,
	output logic [video_geom_pkg::fb_addr_w-1:0] head_addr,
	output pixel_pkg::sram_word_u head_data,
	output logic wq_empty,
	output logic credit_ret
);

	logic [video_geom_pkg::fb_addr_w-1:0] addr_mem [pixel_pkg::wq_depth];
	pixel_pkg::sram_word_u data_mem [pixel_pkg::wq_depth];
	logic [pixel_pkg::wq_ptr_w:0] wr_ptr; // The extra top bit tells full from empty.
	logic [pixel_pkg::wq_ptr_w:0] rd_ptr;
	logic pop_ok;

	assign wq_empty = (wr_ptr == rd_ptr);
	assign pop_ok = wq_pop && !wq_empty; // A pop of an empty queue is ignored.
	assign head_addr = addr_mem[rd_ptr[pixel_pkg::wq_ptr_w-1:0]];
	assign head_data = data_mem[rd_ptr[pixel_pkg::wq_ptr_w-1:0]];

	always_ff @(posedge in_hs) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			credit_ret <= 1'b0;
		end else begin
			if (wr_push) wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
			credit_ret <= pop_ok; // One entry is free again.
		end
	end

	// Storage.
	always_ff @(posedge in_hs) begin
		if (wr_push) begin
			addr_mem[wr_ptr[pixel_pkg::wq_ptr_w-1:0]] <= wr_addr;
			data_mem[wr_ptr[pixel_pkg::wq_ptr_w-1:0]] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* src/frame_control.sv */
// Slot sequencer for the shared SRAM port.
// Four in_hs cycles make one slot cycle. Phase 1 writes and phase 3 reads.
// All SRAM pins are registered, so they change on the edge that ends the phase.
// The SRAM must return read data one cycle after it sees the address.
// out_pclk runs at half the rate of in_hs and rises after phases 0 and 2.
`default_nettype none

module frame_control (
	input  wire  in_hs,
	input  wire  rst,
	input  wire  wq_empty,
	input  wire  [video_geom_pkg::fb_addr_w-1:0] head_addr,
	input  wire  pixel_pkg::sram_word_u head_data,
	input  wire  [video_geom_pkg::fb_addr_w-1:0] rd_addr,
	output logic wq_pop,
	output logic px_step,
	output logic rd_step,
	output logic px_load,
	output logic out_pclk,
	output logic [video_geom_pkg::fb_addr_w-1:0] sram_addr,
	output logic sram_we,
	output logic [15:0] sram_wdata
);

	logic [1:0] phase; // Position in the slot cycle.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase counter.
	always_ff @(posedge in_hs) begin
		if (rst) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 1'b1; // Wraps from 3 back to 0.
		end
	end

	// Slot decode.
	assign px_step = (phase == 2'd0) || (phase == 2'd2); // Two output pixels per cycle.
	assign wq_pop = (phase == 2'd1) && !wq_empty; // The write slot takes the oldest request.
	assign px_load = (phase == 2'd1); // Read data from the last read slot is on the bus now.
	assign rd_step = (phase == 2'd3);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registered SRAM drive.
	always_ff @(posedge in_hs) begin
		if (rst) begin
			out_pclk <= 1'b0;
			sram_we <= 1'b0;
			sram_addr <= '0;
		end else begin
			out_pclk <= px_step;
			sram_we <= wq_pop; // High for one cycle per write.
			if (wq_pop) begin
				sram_addr <= head_addr;
			end else if (rd_step) begin
				sram_addr <= rd_addr; // The read address is held through the next phase.
			end
		end
	end

	// Write data only matters while sram_we is high.
	always_ff @(posedge in_hs) begin
		if (wq_pop) begin
			sram_wdata <= head_data.raw;
		end
	end

endmodule

`default_nettype wire

/* src/raster_timing.sv */
// Output raster counters, sync and read pointer.
// Counters step on px_step, so one output pixel lasts two in_hs cycles.
// Sync and visibility are decoded from the counters without further delay.
// In progressive mode every stored line is read twice by winding the pointer back.
// A mode change in the middle of a frame can misplace lines until the next frame.
`default_nettype none

module raster_timing (
	input  wire  in_hs,
	input  wire  rst,
	input  wire  px_step,
	input  wire  rd_step,
	input  wire  interlaced,
	output logic out_hs,
	output logic out_vs,
	output logic visible,
	output logic [video_geom_pkg::fb_addr_w-1:0] rd_addr
);

	logic [video_geom_pkg::out_h_cnt_w-1:0] h_cnt; // Output pixel in the line.
	logic [video_geom_pkg::out_v_cnt_w-1:0] v_cnt; // Output line in the frame.
	logic line_last;
	logic frame_last;
	logic repeat_flag; // The line just read is shown once more.
	logic [video_geom_pkg::fb_addr_w-1:0] rd_ptr;

	assign line_last = (h_cnt == video_geom_pkg::out_h_total - 1);
	assign frame_last = (v_cnt == video_geom_pkg::out_v_total - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode.
	always_comb begin
		out_hs = (h_cnt >= video_geom_pkg::out_h_fp) &&
			(h_cnt < video_geom_pkg::out_h_fp + video_geom_pkg::out_h_sw);
		out_vs = (v_cnt >= video_geom_pkg::out_v_bp) &&
			(v_cnt < video_geom_pkg::out_v_bp + video_geom_pkg::out_v_sw);
		visible = (h_cnt >= video_geom_pkg::out_h_blank) &&
			(h_cnt < video_geom_pkg::out_h_total) &&
			(v_cnt >= video_geom_pkg::out_v_blank + video_geom_pkg::out_v_offset) &&
			(v_cnt < video_geom_pkg::out_v_blank + video_geom_pkg::out_v_offset +
				video_geom_pkg::fb_height);
		rd_addr = visible ? rd_ptr : '0; // Blanking reads go to address 0.
	end

	// Pixel and line counters.
	always_ff @(posedge in_hs) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (px_step) begin
			if (line_last) begin
				h_cnt <= '0;
				v_cnt <= frame_last ? '0 : v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Read pointer. Line ends come on px_step, so they never meet a read step.
	always_ff @(posedge in_hs) begin
		if (rst) begin
			rd_ptr <= '0;
			repeat_flag <= 1'b0;
		end else if (px_step && line_last) begin
			if (frame_last) begin
				rd_ptr <= '0;
				repeat_flag <= 1'b0;
			end else if (!interlaced) begin
				if (!repeat_flag && rd_ptr != '0) begin
					rd_ptr <= rd_ptr - video_geom_pkg::fb_addr_w'(video_geom_pkg::fb_width);
				end
				repeat_flag <= !repeat_flag;
			end
		end else if (rd_step && visible) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/pixel_out.sv */
// Output pixel register.
// The stored RGB565 word is widened to 8 bits per channel with zero low bits.
// out_data only changes on px_load and is black outside the picture window.
`default_nettype none

module pixel_out (
	input  wire         in_hs,
	input  wire         rst,
	input  wire         px_load,
	input  wire         visible,
	input  wire  [15:0] sram_rdata,
	output logic [23:0] out_data
);

	pixel_pkg::sram_word_u rd_word; // Same bits as the bus, seen as colour fields.

	assign rd_word = sram_rdata;

	always_ff @(posedge in_hs) begin
		if (rst) begin
			out_data <= '0;
		end else if (px_load) begin
			if (visible) begin
				out_data <= {rd_word.rgb.red, 3'b000,
					rd_word.rgb.green, 2'b00,
					rd_word.rgb.blue, 3'b000};
			end else begin
				out_data <= '0; // Border and blanking.
			end
		end
	end

endmodule

`default_nettype wire

/* src/scan_doubler_top.sv */
// Line doubler top level.
// Everything runs on in_hs, and the source markers must already be sampled on it.
// The SRAM has separate write and read data buses and returns read data after one cycle.
// The capture window and the output raster are fixed by the geometry constants.
`default_nettype none

module scan_doubler_top (
	input  wire         in_hs,
	input  wire         rst,
	input  wire         pix_valid,
	input  wire  [29:0] pix_data,
	input  wire         line_end,
	input  wire         frame_end,
	input  wire         field_odd,
	output logic        out_pclk,
	output logic        out_hs,
	output logic        out_vs,
	output logic [23:0] out_data,
	output logic        interlaced,
	output logic [video_geom_pkg::fb_addr_w-1:0] sram_addr,
	output logic        sram_we,
	output logic [15:0] sram_wdata,
	input  wire  [15:0] sram_rdata
);

	// Capture to queue.
	logic wr_push;
	logic [video_geom_pkg::fb_addr_w-1:0] wr_addr;
	pixel_pkg::sram_word_u wr_data;
	logic credit_ret;

	// Queue to slot sequencer.
	logic wq_pop;
	logic wq_empty;
	logic [video_geom_pkg::fb_addr_w-1:0] head_addr;
	pixel_pkg::sram_word_u head_data;

	// Slot sequencer to raster and output register.
	logic px_step;
	logic rd_step;
	logic px_load;
	logic visible;
	logic [video_geom_pkg::fb_addr_w-1:0] rd_addr;

	capture_addr i_capture_addr (
		.in_hs(in_hs), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data),
		.line_end(line_end), .frame_end(frame_end), .field_odd(field_odd),
		.interlaced(interlaced), .credit_ret(credit_ret), .wr_push(wr_push),
		.wr_addr(wr_addr), .wr_data(wr_data)
	);

	interlace_detect i_interlace_detect (
		.in_hs(in_hs), .rst(rst), .frame_end(frame_end), .field_odd(field_odd),
		.interlaced(interlaced)
	);

	write_queue i_write_queue (
		.in_hs(in_hs), .rst(rst), .wr_push(wr_push), .wr_addr(wr_addr), .wr_data(wr_data),
		.wq_pop(wq_pop), .head_addr(head_addr), .head_data(head_data), .wq_empty(wq_empty),
		.credit_ret(credit_ret)
	);

	frame_control i_frame_control (
		.in_hs(in_hs), .rst(rst), .wq_empty(wq_empty), .head_addr(head_addr),
		.head_data(head_data), .rd_addr(rd_addr), .wq_pop(wq_pop), .px_step(px_step),
		.rd_step(rd_step), .px_load(px_load), .out_pclk(out_pclk), .sram_addr(sram_addr),
		.sram_we(sram_we), .sram_wdata(sram_wdata)
	);

	raster_timing i_raster_timing (
		.in_hs(in_hs), .rst(rst), .px_step(px_step), .rd_step(rd_step),
		.interlaced(interlaced), .out_hs(out_hs), .out_vs(out_vs), .visible(visible),
		.rd_addr(rd_addr)
	);

	pixel_out i_pixel_out (
		.in_hs(in_hs), .rst(rst), .px_load(px_load), .visible(visible),
		.sram_rdata(sram_rdata), .out_data(out_data)
	);

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// Clock and reset source for the testbench.
// in_hs has a period of 8 time units, and rst stays high for the first 5 rising edges.
// rst is released on a falling edge, so the DUT sees a clean low at the next rising edge.
`default_nettype none

module tb_clock (
	output logic in_hs,
	output logic rst
);

	initial begin
		in_hs = 1'b0;
		forever #4 in_hs = ~in_hs; // Half period.
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge in_hs);
		@(negedge in_hs);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* test/tb_top.sv */
// Testbench for the line doubler top level.
// The SRAM model has one cycle of read latency and logs every write it takes.
// Inputs change on the falling edge of in_hs. Outputs are sampled on falling edges too.
// Capture frames are 12 pixels by 5 lines, so the window covers x 2..9 and y 1..3.
// Output samples are taken once per output pixel, on each rising edge of out_pclk.
`default_nettype none

module tb_top;

	localparam int in_width = 12; // Pixels per input line.
	localparam int in_lines = 5; // Lines per input field.
	localparam int frame_rows = 12;

	// Frame table. Field flag, mode before and after the frame, and one probed pixel.
	localparam int tab_field [frame_rows] = '{1, 0, 1, 0, 0, 1, 1, 1, 1, 1, 1, 1};
	localparam int tab_mode_before [frame_rows] = '{0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1};
	localparam int tab_mode_after [frame_rows] = '{0, 0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 0};
	localparam int tab_probe_x [frame_rows] = '{9, 2, 5, 9, 5, 2, 9, 3, 6, 2, 9, 4};
	localparam int tab_probe_y [frame_rows] = '{3, 1, 2, 1, 2, 3, 1, 2, 3, 1, 3, 2};
	localparam int tab_probe_addr [frame_rows] = '{23, 0, 11, 7, 19, 40, 15, 25, 44, 8, 47, 26};

	logic in_hs;
	logic rst;
	logic pix_valid;
	logic [29:0] pix_data;
	logic line_end;
	logic frame_end;
	logic field_odd;
	logic out_pclk;
	logic out_hs;
	logic out_vs;
	logic [23:0] out_data;
	logic interlaced;
	logic [video_geom_pkg::fb_addr_w-1:0] sram_addr;
	logic sram_we;
	logic [15:0] sram_wdata;
	logic [15:0] sram_rdata = '0;

	logic [15:0] sram_mem [64];
	logic preload; // Fills the SRAM with the known pattern on the next rising edge.
	logic [5:0] wlog_addr [$]; // Writes seen by the SRAM, oldest first.
	logic [15:0] wlog_data [$];
	logic [5:0] exp_addr [$]; // Writes that the capture rules predict.
	logic [15:0] exp_data [$];
	logic [15:0] sent_word [in_width * in_lines]; // Packed colour per input position.
	logic [15:0] sent_by_addr [64];
	bit sent_valid [64];

	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int h_pos; // Output position of the current sample.
	int v_pos;

	tb_clock i_clock (.in_hs(in_hs), .rst(rst));

	scan_doubler_top i_dut (
		.in_hs(in_hs), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data),
		.line_end(line_end), .frame_end(frame_end), .field_odd(field_odd),
		.out_pclk(out_pclk), .out_hs(out_hs), .out_vs(out_vs), .out_data(out_data),
		.interlaced(interlaced), .sram_addr(sram_addr), .sram_we(sram_we),
		.sram_wdata(sram_wdata), .sram_rdata(sram_rdata)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SRAM model.
	always @(posedge in_hs) begin
		if (preload) begin
			for (int a = 0; a < 64; a++) sram_mem[a] <= fill_word(6'(a));
		end else if (sram_we) begin
			sram_mem[sram_addr] <= sram_wdata;
		end
		if (sram_we) begin
			wlog_addr.push_back(sram_addr); // Every write is logged in order.
			wlog_data.push_back(sram_wdata);
		end
		sram_rdata <= sram_mem[sram_addr]; // Data follows the address by one cycle.
	end

	// Every bit of the address shows up in the word.
	function automatic logic [15:0] fill_word(logic [5:0] a);
		return {a, ~a, a[3:0]};
	endfunction

	// Top 5, 6 and 5 bits of the three 10-bit channels.
	function automatic logic [15:0] pack565(logic [29:0] d);
		return {d[29:25], d[19:14], d[9:5]};
	endfunction

	function automatic logic [23:0] expand565(logic [15:0] w);
		return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
	endfunction

	function automatic bit in_capture_window(int x, int y);
		return x >= video_geom_pkg::in_h_offset &&
			x < video_geom_pkg::in_h_offset + video_geom_pkg::fb_width &&
			y >= video_geom_pkg::in_v_offset &&
			y < video_geom_pkg::in_v_offset + video_geom_pkg::fb_field_lines;
	endfunction

	function automatic int capture_address(int x, int y, int field, bit mode);
		int line;
		line = y - video_geom_pkg::in_v_offset;
		if (mode) line = 2 * line + field; // Fields interleave.
		return line * video_geom_pkg::fb_width + x - video_geom_pkg::in_h_offset;
	endfunction

	// Picture at an output position in progressive mode, with each stored line shown twice.
	function automatic logic [23:0] expect_pixel(int h, int v);
		int first_line;
		int a;
		first_line = video_geom_pkg::out_v_blank + video_geom_pkg::out_v_offset;
		if (h < video_geom_pkg::out_h_blank || h >= video_geom_pkg::out_h_total) return '0;
		if (v < first_line || v >= first_line + video_geom_pkg::fb_height) return '0;
		a = ((v - first_line) / 2) * video_geom_pkg::fb_width + (h - video_geom_pkg::out_h_blank) / 2;
		return expand565(fill_word(6'(a)));
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and reporting.
	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got == exp) else begin
			$display("error %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_true(bit cond, string what);
		assert (cond) else begin
			$display("%s", what);
			test_errors++;
		end
	endtask

	task automatic end_test(int num, string name);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("test %0d %s: %s, %0d errors", num, name,
			(test_errors == 0) ? "ok" : "FAILED", test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	task automatic abort_run(string what);
		$display("timeout while waiting: %s", what);
		$display("Checks failed");
		$finish;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Input driving.
	task automatic drive(logic valid, logic [29:0] data, logic le, logic fe);
		@(negedge in_hs);
		pix_valid = valid;
		pix_data = data;
		line_end = le;
		frame_end = fe;
	endtask

	// One field. Paced pixels leave room for the queue, a burst sends one pixel per cycle.
	task automatic send_frame(int field, bit paced, bit mode);
		logic [29:0] data;
		logic [15:0] word;
		int a;
		int line_start;
		int snap;
		drive(1'b0, '0, 1'b0, 1'b0);
		field_odd = field[0];
		for (int y = 0; y < in_lines; y++) begin
			line_start = wlog_addr.size();
			for (int x = 0; x < in_width; x++) begin
				data = 30'($urandom);
				word = pack565(data);
				sent_word[y * in_width + x] = word;
				if (in_capture_window(x, y)) begin
					a = capture_address(x, y, field, mode);
					exp_addr.push_back(6'(a));
					exp_data.push_back(word);
					sent_by_addr[a] = word;
					sent_valid[a] = 1'b1;
				end
				drive(1'b1, data, 1'b0, 1'b0);
				if (paced) repeat (5) drive(1'b0, data, 1'b0, 1'b0);
			end
			snap = wlog_addr.size(); // Anything written later was still queued.
			drive(1'b0, '0, 1'b1, 1'b0);
			repeat (paced ? 2 : 40) drive(1'b0, '0, 1'b0, 1'b0);
			if (!paced && in_capture_window(video_geom_pkg::in_h_offset, y)) begin
				check_true(wlog_addr.size() - snap <= pixel_pkg::wq_depth,
					"more writes were outstanding than the queue can hold");
				check_true(wlog_addr.size() - line_start >= pixel_pkg::wq_depth,
					"fewer writes than the initial credits allow reached the SRAM");
			end
		end
		drive(1'b0, '0, 1'b0, 1'b1);
		repeat (3) drive(1'b0, '0, 1'b0, 1'b0);
	endtask

	task automatic clear_logs();
		wlog_addr.delete();
		wlog_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic wait_writes(int count);
		int n;
		for (n = 0; n < 400; n++) begin
			if (wlog_addr.size() >= count) break;
			@(negedge in_hs);
		end
		if (n == 400) abort_run("captured pixels never reached the SRAM");
	endtask

	task automatic compare_writes();
		int n;
		check_value("write_count", 32'(wlog_addr.size()), 32'(exp_addr.size()));
		n = (wlog_addr.size() < exp_addr.size()) ? wlog_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check_value("sram_addr", 32'(wlog_addr[i]), 32'(exp_addr[i]));
			check_value("sram_wdata", 32'(wlog_data[i]), 32'(exp_data[i]));
		end
	endtask

	task automatic check_probe(int row);
		bit found;
		found = 1'b0;
		for (int i = 0; i < wlog_addr.size(); i++) begin
			if (wlog_addr[i] == 6'(tab_probe_addr[row])) begin
				found = 1'b1;
				check_value("probe_wdata", 32'(wlog_data[i]),
					32'(sent_word[tab_probe_y[row] * in_width + tab_probe_x[row]]));
			end
		end
		check_true(found, "the probed pixel was not written to its address");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output sampling.
	task automatic next_pixel();
		logic last;
		int n;
		last = out_pclk;
		for (n = 0; n < 8; n++) begin
			@(negedge in_hs);
			if (out_pclk && !last) break; // A rising edge of the output pixel clock.
			last = out_pclk;
		end
		if (n == 8) abort_run("out_pclk stopped toggling");
	endtask

	task automatic advance_position();
		h_pos++;
		if (h_pos == video_geom_pkg::out_h_total) begin
			h_pos = 0;
			v_pos++;
			if (v_pos == video_geom_pkg::out_v_total) v_pos = 0;
		end
	endtask

	task automatic wait_vs(logic level);
		int n;
		for (n = 0; n < 400; n++) begin
			next_pixel();
			if (out_vs == level) break;
		end
		if (n == 400) abort_run("out_vs never changed");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	initial begin
		int n;
		int hs_count;
		int vs_count;
		int last_count;
		logic [23:0] prev1;
		logic [23:0] prev2;
		logic [5:0] a;
		bit seen [64];
		pix_valid = 1'b0;
		pix_data = '0;
		line_end = 1'b0;
		frame_end = 1'b0;
		field_odd = 1'b1;
		preload = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		n = $urandom(32'h21c7e39b); // Seeds the colour stream.

		// Test 1. Outputs during reset and one cycle after it.
		@(negedge in_hs);
		check_value("out_pclk", 32'(out_pclk), 0); // Reset is still held here.
		for (n = 0; n < 20; n++) begin
			@(posedge in_hs);
			if (!rst) break;
		end
		if (n == 20) abort_run("reset was never released");
		@(negedge in_hs);
		check_value("sram_we", 32'(sram_we), 0);
		check_value("out_hs", 32'(out_hs), 0);
		check_value("out_vs", 32'(out_vs), 0);
		check_value("out_data", 32'(out_data), 0);
		check_value("interlaced", 32'(interlaced), 0);
		end_test(1, "reset");

		// Tests 2 and 3. Row 0 is progressive capture and the rest drive mode detection.
		for (int r = 0; r < frame_rows; r++) begin
			if (r == 1) end_test(2, "progressive capture");
			check_value("interlaced", 32'(interlaced), 32'(tab_mode_before[r]));
			clear_logs();
			send_frame(tab_field[r], 1'b1, 1'(tab_mode_before[r]));
			wait_writes(exp_addr.size());
			repeat (30) drive(1'b0, '0, 1'b0, 1'b0); // Stray writes would show up here.
			compare_writes();
			check_probe(r);
			check_value("interlaced", 32'(interlaced), 32'(tab_mode_after[r]));
		end
		end_test(3, "interlace detection");

		// Test 4. Sync pulses over one frame, counted from the start of vertical sync.
		wait_vs(1'b0);
		wait_vs(1'b1);
		h_pos = 0;
		v_pos = video_geom_pkg::out_v_bp;
		hs_count = 0;
		vs_count = 0;
		for (int s = 0; s < video_geom_pkg::out_h_total * video_geom_pkg::out_v_total; s++) begin
			check_value("out_hs", 32'(out_hs), 32'(h_pos >= video_geom_pkg::out_h_fp &&
				h_pos < video_geom_pkg::out_h_fp + video_geom_pkg::out_h_sw));
			check_value("out_vs", 32'(out_vs), 32'(v_pos >= video_geom_pkg::out_v_bp &&
				v_pos < video_geom_pkg::out_v_bp + video_geom_pkg::out_v_sw));
			hs_count += out_hs;
			vs_count += out_vs;
			advance_position();
			next_pixel();
		end
		check_value("out_hs_count", 32'(hs_count),
			32'(video_geom_pkg::out_h_sw * video_geom_pkg::out_v_total));
		check_value("out_vs_count", 32'(vs_count),
			32'(video_geom_pkg::out_v_sw * video_geom_pkg::out_h_total));
		end_test(4, "raster sync");

		// Test 5. A known frame is read back. A loaded word shows two output pixels later.
		check_value("interlaced", 32'(interlaced), 0);
		preload = 1'b1; // The SRAM model takes it on the next rising edge.
		@(negedge in_hs);
		preload = 1'b0;
		advance_position();
		next_pixel();
		for (n = 0; n < 400; n++) begin
			if (h_pos == 0 && v_pos == 0) break;
			advance_position();
			next_pixel();
		end
		if (n == 400) abort_run("the output frame never restarted");
		prev1 = '0;
		prev2 = '0; // The last line of a frame is black.
		for (int s = 0; s < video_geom_pkg::out_h_total * video_geom_pkg::out_v_total; s++) begin
			check_value("out_data", 32'(out_data), 32'(prev2));
			prev2 = prev1;
			prev1 = expect_pixel(h_pos, v_pos);
			advance_position();
			next_pixel();
		end
		end_test(5, "readback");

		// Test 6. Back-to-back pixels exhaust the credits.
		for (int i = 0; i < 64; i++) begin
			sent_valid[i] = 1'b0;
			seen[i] = 1'b0;
		end
		clear_logs();
		send_frame(1, 1'b0, 1'(tab_mode_after[frame_rows - 1]));
		last_count = wlog_addr.size();
		repeat (40) drive(1'b0, '0, 1'b0, 1'b0);
		check_true(wlog_addr.size() == last_count, "writes kept coming after the queue drained");
		for (int i = 0; i < wlog_addr.size(); i++) begin
			a = wlog_addr[i];
			check_true(sent_valid[a], "a write went to an address that no pixel maps to");
			check_true(!seen[a], "an SRAM address was written twice");
			seen[a] = 1'b1;
			check_value("sram_wdata", 32'(wlog_data[i]), 32'(sent_by_addr[a]));
		end
		end_test(6, "back-pressure");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
src/video_geom_pkg.sv
src/pixel_pkg.sv
src/capture_addr.sv
src/interlace_detect.sv
src/write_queue.sv
src/frame_control.sv
src/raster_timing.sv
src/pixel_out.sv
src/scan_doubler_top.sv
test/tb_clock.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in the log.
rm -f sim.log && \
verilator --binary --timing --assert -f files.f --top-module tb_top -Mdir obj_dir -o tb_sim && \
./obj_dir/tb_sim > sim.log || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "All checks passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
